// ==== all.f ====
source/fix_proto_pkg.sv
source/fix_stream_pkg.sv
source/fix_tokenizer.sv
source/fix_field_extractor.sv
source/field_fifo.sv
source/fix_message_framer.sv
source/fix_parser_top.sv
verification/fix_parser_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the FIX parser testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f all.f \
	--top-module fix_parser_tb -o fix_parser_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/fix_parser_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Verification passed" sim.log; then
	exit 0
fi
echo "simulation did not pass (status $sim_status), see sim.log"
exit 1

// ==== source/field_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module field_fifo (
	input wire clk,
	input wire rst,
	input wire push_i,
	input wire fix_stream_pkg::field_t data_i,
	input wire pop_i,
	output fix_stream_pkg::field_t head_o,
	output logic empty_o,
	output logic overflow_o
);

	import fix_stream_pkg::*;

	field_t mem [fifo_depth];
	logic [$clog2(fifo_depth)-1:0] wr_ptr;
	logic [$clog2(fifo_depth)-1:0] rd_ptr;
	logic [$clog2(fifo_depth):0] count;
	logic full;
	logic do_push;
	logic do_pop;

	assign full = (count == $bits(count)'(fifo_depth));
	assign empty_o = (count == '0);
	// a push into a full buffer is lost
	assign do_push = push_i && !full;
	assign do_pop = pop_i && !empty_o;
	assign head_o = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow_o <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
			// sticky until reset
			if (push_i && full) begin
				overflow_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= data_i;
		end
	end

	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop_i |-> !empty_o);

	a_count_bound: assert property (@(posedge clk) disable iff (rst) count <= fifo_depth);

endmodule

`default_nettype wire

// ==== source/fix_field_extractor.sv ====
`timescale 1ns/10ps
`default_nettype none

module fix_field_extractor (
	input wire clk,
	input wire rst,
	input wire fix_stream_pkg::token_t token_i,
	input wire token_valid_i,
	output fix_stream_pkg::field_t field_o,
	output logic push_o
);

	import fix_proto_pkg::*;
	import fix_stream_pkg::*;

	extract_state_e state;
	extract_state_e next_state;
	field_t field_q;

	always_comb begin
		// write lasts a single cycle
		next_state = (state == write) ? idle : state;
		if (token_valid_i) begin
			unique case (state)
				idle, write: begin
					if (token_i.kind == tok_tag) begin
						next_state = in_tag;
					end else if (token_i.kind == tok_eq) begin
						next_state = in_value;
					end
				end
				in_tag: begin
					if (token_i.kind == tok_eq) begin
						next_state = in_value;
					end else if (token_i.kind == tok_soh) begin
						// no "=" seen, drop the partial field
						next_state = idle;
					end
				end
				in_value: begin
					if (token_i.kind == tok_soh) begin
						next_state = write;
					end
				end
				default: next_state = idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
		end else begin
			state <= next_state;
		end
	end

	// tag and value shift in from the low byte
	always_ff @(posedge clk) begin
		if (token_valid_i) begin
			case (token_i.kind)
				tok_tag: begin
					if (state == in_tag) begin
						field_q.tag <= {field_q.tag[tag_w-9:0], token_i.data};
					end else begin
						field_q.tag <= {{(tag_w-8){1'b0}}, token_i.data};
					end
				end
				tok_eq: begin
					if (state != in_tag) begin
						field_q.tag <= '0;
					end
					field_q.value <= '0;
					field_q.value_len <= '0;
				end
				tok_value: begin
					if (state == in_value) begin
						field_q.value <= {field_q.value[value_w-9:0], token_i.data};
						// saturate, older bytes fall off the top
						if (field_q.value_len != len_w'(value_bytes)) begin
							field_q.value_len <= field_q.value_len + 1'b1;
						end
					end
				end
				tok_soh: begin
					field_q.is_begin <= (field_q.tag == begin_tag);
					field_q.is_checksum <= (field_q.tag == checksum_tag);
				end
				default: ;
			endcase
		end
	end

	assign field_o = field_q;
	assign push_o = (state == write);

	a_push_single: assert property (@(posedge clk) disable iff (rst)
		push_o |=> !push_o);

endmodule

`default_nettype wire

// ==== source/fix_message_framer.sv ====
`timescale 1ns/10ps
`default_nettype none

module fix_message_framer (
	input wire clk,
	input wire rst,
	input wire fix_stream_pkg::field_t head_i,
	input wire empty_i,
	input wire hold_i,
	output logic pop_o,
	output fix_stream_pkg::field_t field_o,
	output logic field_valid_o,
	output logic [fix_stream_pkg::field_idx_w-1:0] field_index_o,
	output logic msg_start_o,
	output logic msg_end_o
);

	import fix_stream_pkg::*;

	logic in_msg;
	// index of the next field inside the message
	logic [field_idx_w-1:0] field_cnt;

	assign pop_o = !empty_i && !hold_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			in_msg <= 1'b0;
			field_cnt <= '0;
			field_valid_o <= 1'b0;
			msg_start_o <= 1'b0;
			msg_end_o <= 1'b0;
		end else begin
			field_valid_o <= 1'b0;
			msg_start_o <= 1'b0;
			msg_end_o <= 1'b0;
			if (pop_o) begin
				if (head_i.is_begin) begin
					// tag 8 always opens a new message
					in_msg <= 1'b1;
					field_cnt <= field_idx_w'(1);
					field_valid_o <= 1'b1;
					msg_start_o <= 1'b1;
				end else if (in_msg) begin
					field_cnt <= field_cnt + 1'b1;
					field_valid_o <= 1'b1;
					if (head_i.is_checksum) begin
						msg_end_o <= 1'b1;
						in_msg <= 1'b0;
					end
				end
				// fields outside a message are just dropped
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pop_o) begin
			field_o <= head_i;
			field_index_o <= head_i.is_begin ? '0 : field_cnt;
		end
	end

endmodule

`default_nettype wire

// ==== source/fix_parser_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module fix_parser_top (
	input wire clk,
	input wire rst,
	input wire [7:0] byte_i,
	input wire byte_valid_i,
	input wire hold_i,
	output fix_stream_pkg::field_t field_o,
	output logic field_valid_o,
	output logic [fix_stream_pkg::field_idx_w-1:0] field_index_o,
	output logic msg_start_o,
	output logic msg_end_o,
	output logic overflow_o
);

	import fix_stream_pkg::*;

	token_t token;
	logic token_valid;
	field_t ext_field;
	logic push;
	field_t head;
	logic empty;
	logic pop;

	fix_tokenizer fix_tokenizer_i (
		.clk(clk),
		.rst(rst),
		.byte_i(byte_i),
		.byte_valid_i(byte_valid_i),
		.token_o(token),
		.token_valid_o(token_valid)
	);

	fix_field_extractor fix_field_extractor_i (
		.clk(clk),
		.rst(rst),
		.token_i(token),
		.token_valid_i(token_valid),
		.field_o(ext_field),
		.push_o(push)
	);

	field_fifo field_fifo_i (
		.clk(clk),
		.rst(rst),
		.push_i(push),
		.data_i(ext_field),
		.pop_i(pop),
		.head_o(head),
		.empty_o(empty),
		.overflow_o(overflow_o)
	);

	fix_message_framer fix_message_framer_i (
		.clk(clk),
		.rst(rst),
		.head_i(head),
		.empty_i(empty),
		.hold_i(hold_i),
		.pop_o(pop),
		.field_o(field_o),
		.field_valid_o(field_valid_o),
		.field_index_o(field_index_o),
		.msg_start_o(msg_start_o),
		.msg_end_o(msg_end_o)
	);

endmodule

`default_nettype wire

// ==== source/fix_proto_pkg.sv ====
`default_nettype none

package fix_proto_pkg;

	// field separator and tag/value separator
	localparam logic [7:0] soh_byte = 8'h01;
	localparam logic [7:0] eq_byte = 8'h3d;

	// storage sizes in bytes
	localparam int tag_bytes = 4;
	localparam int value_bytes = 32;

	localparam int tag_w = tag_bytes * 8;
	localparam int value_w = value_bytes * 8;

	// enough bits to hold a length of value_bytes
	localparam int len_w = 6;

	// ascii "8", right aligned
	localparam logic [tag_w-1:0] begin_tag = 32'h0000_0038;

	// ascii "10", right aligned
	localparam logic [tag_w-1:0] checksum_tag = 32'h0000_3130;

endpackage

`default_nettype wire

// ==== source/fix_stream_pkg.sv ====
`default_nettype none

package fix_stream_pkg;

	typedef enum logic [1:0] {
		tok_tag,
		tok_eq,
		tok_value,
		tok_soh
	} token_kind_e;

	typedef struct packed {
		token_kind_e kind;
		logic [7:0] data;
	} token_t;

	// one finished tag=value field
	typedef struct packed {
		logic [fix_proto_pkg::tag_w-1:0] tag;
		logic [fix_proto_pkg::value_w-1:0] value;
		logic [fix_proto_pkg::len_w-1:0] value_len;
		logic is_begin;
		logic is_checksum;
	} field_t;

	typedef enum logic [1:0] {
		idle,
		in_tag,
		in_value,
		write
	} extract_state_e;

	localparam int fifo_depth = 4;
	localparam int field_idx_w = 8;

endpackage

`default_nettype wire

// ==== source/fix_tokenizer.sv ====
`timescale 1ns/10ps
`default_nettype none

module fix_tokenizer (
	input wire clk,
	input wire rst,
	input wire [7:0] byte_i,
	input wire byte_valid_i,
	output fix_stream_pkg::token_t token_o,
	output logic token_valid_o
);

	import fix_proto_pkg::*;
	import fix_stream_pkg::*;

	// set once the first "=" of a field has been seen
	logic after_eq;
	token_kind_e byte_kind;

	always_comb begin
		if (byte_i == soh_byte) begin
			byte_kind = tok_soh;
		end else if (after_eq) begin
			// later "=" bytes belong to the value
			byte_kind = tok_value;
		end else if (byte_i == eq_byte) begin
			byte_kind = tok_eq;
		end else begin
			byte_kind = tok_tag;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			after_eq <= 1'b0;
			token_valid_o <= 1'b0;
		end else begin
			token_valid_o <= byte_valid_i;
			if (byte_valid_i) begin
				if (byte_kind == tok_soh) begin
					after_eq <= 1'b0;
				end else if (byte_kind == tok_eq) begin
					after_eq <= 1'b1;
				end
			end
		end
	end

	// token payload, only meaningful with token_valid_o
	always_ff @(posedge clk) begin
		if (byte_valid_i) begin
			token_o.kind <= byte_kind;
			token_o.data <= byte_i;
		end
	end

	a_valid_follows: assert property (@(posedge clk) disable iff (rst)
		byte_valid_i |=> token_valid_o);

endmodule

`default_nettype wire

// ==== verification/fix_parser_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module fix_parser_tb;

	import fix_proto_pkg::*;
	import fix_stream_pkg::*;

	localparam int wait_limit = 200;
	localparam int quiet_cycles = 20;

	logic clk;
	logic rst;
	logic [7:0] byte_i;
	logic byte_valid_i;
	logic hold_i;
	field_t field_o;
	logic field_valid_o;
	logic [field_idx_w-1:0] field_index_o;
	logic msg_start_o;
	logic msg_end_o;
	logic overflow_o;

	int seed = 26;
	bit hold_forced;

	// stimulus table, one row per field
	int msg_tbl[$];
	string tag_tbl[$];
	string value_tbl[$];
	bit eq_tbl[$];
	bit emit_tbl[$];
	int idx_tbl[$];
	bit start_tbl[$];
	bit end_tbl[$];
	bit held_tbl[$];
	int pending[$];

	fix_parser_top fix_parser_top_i (
		.clk(clk),
		.rst(rst),
		.byte_i(byte_i),
		.byte_valid_i(byte_valid_i),
		.hold_i(hold_i),
		.field_o(field_o),
		.field_valid_o(field_valid_o),
		.field_index_o(field_index_o),
		.msg_start_o(msg_start_o),
		.msg_end_o(msg_end_o),
		.overflow_o(overflow_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic add_entry(input int msg, input string tag_s, input string val_s,
			input bit has_eq, input bit emits, input int idx, input bit start,
			input bit last, input bit held);
		msg_tbl.push_back(msg);
		tag_tbl.push_back(tag_s);
		value_tbl.push_back(val_s);
		eq_tbl.push_back(has_eq);
		emit_tbl.push_back(emits);
		idx_tbl.push_back(idx);
		start_tbl.push_back(start);
		end_tbl.push_back(last);
		held_tbl.push_back(held);
	endtask

	task automatic stop_run(input string why);
		$display("Verification failed");
		$fatal(1, "%s", why);
	endtask

	task automatic compare_field(input string name, input field_t got, input field_t exp);
		if (got !== exp) begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_run("field mismatch");
		end
	endtask

	task automatic compare_index(input string name, input logic [field_idx_w-1:0] got,
			input logic [field_idx_w-1:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_run("index mismatch");
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_run("flag mismatch");
		end
	endtask

	// ascii right aligned, only the last bytes are kept
	function automatic field_t expected_field(input string tag_s, input string val_s);
		field_t f;
		int n;
		int k;
		f = '0;
		n = tag_s.len();
		for (k = 0; k < n && k < tag_bytes; k++) begin
			f.tag[k*8 +: 8] = tag_s[n-1-k];
		end
		n = val_s.len();
		for (k = 0; k < n && k < value_bytes; k++) begin
			f.value[k*8 +: 8] = val_s[n-1-k];
		end
		f.value_len = len_w'((n > value_bytes) ? value_bytes : n);
		f.is_begin = (tag_s == "8");
		f.is_checksum = (tag_s == "10");
		return f;
	endfunction

	task automatic drive_hold();
		if (hold_forced) begin
			hold_i = 1'b1;
		end else begin
			hold_i = (($random(seed) & 3) == 0);
		end
	endtask

	task automatic send_byte(input logic [7:0] b);
		int unsigned gap;
		gap = $unsigned($random(seed)) % 3;
		repeat (gap) begin
			@(negedge clk);
			byte_valid_i = 1'b0;
			drive_hold();
		end
		@(negedge clk);
		byte_i = b;
		byte_valid_i = 1'b1;
		drive_hold();
	endtask

	task automatic send_field(input int i);
		int k;
		for (k = 0; k < tag_tbl[i].len(); k++) begin
			send_byte(tag_tbl[i][k]);
		end
		if (eq_tbl[i]) begin
			send_byte(eq_byte);
		end
		for (k = 0; k < value_tbl[i].len(); k++) begin
			send_byte(value_tbl[i][k]);
		end
		send_byte(soh_byte);
		@(negedge clk);
		byte_valid_i = 1'b0;
		drive_hold();
	endtask

	task automatic check_output(input int i);
		int cycles;
		cycles = 0;
		@(negedge clk);
		drive_hold();
		while (!field_valid_o) begin
			if (cycles == wait_limit) begin
				$display("timeout waiting for field_valid_o, message %0d tag %s",
					msg_tbl[i], tag_tbl[i]);
				stop_run("no field came out");
			end
			cycles++;
			@(negedge clk);
			drive_hold();
		end
		compare_field("field_o", field_o, expected_field(tag_tbl[i], value_tbl[i]));
		compare_index("field_index_o", field_index_o, field_idx_w'(idx_tbl[i]));
		compare_flag("msg_start_o", msg_start_o, start_tbl[i]);
		compare_flag("msg_end_o", msg_end_o, end_tbl[i]);
	endtask

	task automatic wait_overflow();
		int cycles;
		cycles = 0;
		while (!overflow_o) begin
			if (cycles == wait_limit) begin
				$display("timeout waiting for overflow_o to rise");
				stop_run("overflow never seen");
			end
			cycles++;
			@(negedge clk);
			drive_hold();
		end
	endtask

	task automatic check_quiet();
		repeat (quiet_cycles) begin
			@(negedge clk);
			drive_hold();
			if (field_valid_o) begin
				$display("an extra field came out after the last expected one");
				stop_run("unexpected field");
			end
		end
	endtask

	initial begin
		rst = 1'b1;
		byte_i = 8'h00;
		byte_valid_i = 1'b0;
		hold_i = 1'b0;
		hold_forced = 1'b0;

		// msg, tag, value, has "=", emits, index, start, end, held
		add_entry(0, "8", "FIX.4.2", 1, 1, 0, 1, 0, 0);
		add_entry(0, "35", "D", 1, 1, 1, 0, 0, 0);
		add_entry(0, "10", "123", 1, 1, 2, 0, 1, 0);
		add_entry(1, "8", "FIX.4.4", 1, 1, 0, 1, 0, 0);
		add_entry(1, "58", "ABCDEFGHIJKLMNOPQRSTUVWXYZ0123456789abcd", 1, 1, 1, 0, 0, 0);
		add_entry(1, "10", "045", 1, 1, 2, 0, 1, 0);
		// outside any message, then a field with no "="
		add_entry(-1, "55", "IBM", 1, 0, 0, 0, 0, 0);
		add_entry(-1, "99", "", 0, 0, 0, 0, 0, 0);
		add_entry(2, "8", "FIX.4.2", 1, 1, 0, 1, 0, 0);
		add_entry(2, "10049", "X", 1, 1, 1, 0, 0, 0);
		add_entry(2, "10", "001", 1, 1, 2, 0, 1, 0);
		// sent under hold, the fifth one finds the FIFO full
		add_entry(3, "8", "FIX.4.2", 1, 1, 0, 1, 0, 1);
		add_entry(3, "35", "D", 1, 1, 1, 0, 0, 1);
		add_entry(3, "49", "SND", 1, 1, 2, 0, 0, 1);
		add_entry(3, "56", "TGT", 1, 1, 3, 0, 0, 1);
		add_entry(3, "10", "200", 1, 0, 0, 0, 0, 1);

		// four rising edges with reset high
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		compare_flag("field_valid_o", field_valid_o, 1'b0);
		compare_flag("msg_start_o", msg_start_o, 1'b0);
		compare_flag("msg_end_o", msg_end_o, 1'b0);
		compare_flag("overflow_o", overflow_o, 1'b0);

		for (int i = 0; i < tag_tbl.size(); i++) begin
			if (held_tbl[i] && !hold_forced) begin
				compare_flag("overflow_o", overflow_o, 1'b0);
				hold_forced = 1'b1;
				hold_i = 1'b1;
			end
			send_field(i);
			if (emit_tbl[i] && held_tbl[i]) begin
				pending.push_back(i);
			end else if (emit_tbl[i]) begin
				check_output(i);
			end
		end

		wait_overflow();
		hold_forced = 1'b0;
		hold_i = 1'b0;
		while (pending.size() > 0) begin
			check_output(pending.pop_front());
		end
		check_quiet();
		compare_flag("overflow_o", overflow_o, 1'b1);

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire
